/* common/csr_defines.svh */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// number of hart slices in the read stage
`define CSR_HARTS 4

`define CSR_ADDR_W 12
`define CSR_DATA_W 32

// machine-mode CSRs backed by storage
`define CSR_MSTATUS  12'h300
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342

`endif

/* common/csr_pkg.sv */
`include "csr_defines.svh"

package csr_pkg;

    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [`CSR_DATA_W-1:0] csr_data_t;

    // hart index, sized from the slice count
    typedef logic [$clog2(`CSR_HARTS)-1:0] hart_id_t;

    // one forwarding source from an instruction still in flight
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t data;
    } csr_fwd_t;

    // read request, optionally carrying the write of the same instruction
    typedef struct packed {
        hart_id_t  hart;
        csr_addr_t raddr;
        logic      wen;
        csr_addr_t waddr;
        csr_data_t wdata;
    } csr_req_t;

    // answer of one slice, valid low means the read has to wait
    typedef struct packed {
        logic      valid;
        hart_id_t  hart;
        csr_addr_t raddr;
        csr_data_t rdata;
    } csr_rsp_t;

endpackage

/* csr/csr_storage.sv */
`include "csr_defines.svh"

module csr_storage (
    input  logic               CLK,
    input  logic               rst,
    input  logic               wen,
    input  csr_pkg::csr_addr_t waddr,
    input  csr_pkg::csr_data_t wdata,
    input  csr_pkg::csr_addr_t raddr,
    output csr_pkg::csr_data_t rdata
);
    import csr_pkg::*;

    csr_data_t mstatus_q;
    csr_data_t mtvec_q;
    csr_data_t mscratch_q;
    csr_data_t mepc_q;
    csr_data_t mcause_q;

    // single write port, unknown addresses fall through
    always_ff @(posedge CLK) begin
        if (rst) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (wen) begin
            case (waddr)
                `CSR_MSTATUS: begin
                    mstatus_q <= wdata;
                end
                `CSR_MTVEC: begin
                    mtvec_q <= wdata;
                end
                `CSR_MSCRATCH: begin
                    mscratch_q <= wdata;
                end
                `CSR_MEPC: begin
                    mepc_q <= wdata;
                end
                `CSR_MCAUSE: begin
                    mcause_q <= wdata;
                end
                default: begin
                end
            endcase
        end
    end

    // unimplemented CSRs read as zero
    always_comb begin
        case (raddr)
            `CSR_MSTATUS: begin
                rdata = mstatus_q;
            end
            `CSR_MTVEC: begin
                rdata = mtvec_q;
            end
            `CSR_MSCRATCH: begin
                rdata = mscratch_q;
            end
            `CSR_MEPC: begin
                rdata = mepc_q;
            end
            `CSR_MCAUSE: begin
                rdata = mcause_q;
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

endmodule

/* csr/csr_forward_read.sv */
module csr_forward_read (
    input  logic               CLK,
    input  logic               rst,
    input  logic               flush,
    input  logic               stall,
    input  logic               mem_wait,
    input  logic               sel,
    input  csr_pkg::csr_req_t  req,
    input  csr_pkg::csr_addr_t hazard_addr,
    input  csr_pkg::csr_fwd_t  fwd_exec,
    input  csr_pkg::csr_fwd_t  fwd_cushion,
    output logic               slot_strobe,
    output csr_pkg::csr_rsp_t  slot_rsp
);
    import csr_pkg::*;

    csr_req_t  req_q;
    csr_addr_t hazard_q;
    csr_fwd_t  exec_q;
    csr_fwd_t  cushion_q;
    logic      sel_q;

    csr_data_t store_rdata;
    logic      commit;
    logic      rd_valid;
    csr_data_t rd_data;

    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            req_q     <= '0;
            hazard_q  <= '0;
            exec_q    <= '0;
            cushion_q <= '0;
            sel_q     <= 1'b0;
        end else if (stall) begin
            // request is kept, only the forwarding view keeps moving
            hazard_q  <= '0;
            sel_q     <= 1'b0;
            exec_q    <= fwd_exec;
            cushion_q <= fwd_cushion;
        end else if (!mem_wait) begin
            req_q     <= req;
            hazard_q  <= hazard_addr;
            exec_q    <= fwd_exec;
            cushion_q <= fwd_cushion;
            sel_q     <= sel;
        end
    end

    assign slot_strobe = sel_q && !mem_wait;

    // write retires on the same edge that takes the next request
    assign commit = slot_strobe && req_q.wen;

    csr_storage u_storage (
        .CLK   (CLK),
        .rst   (rst),
        .wen   (commit),
        .waddr (req_q.waddr),
        .wdata (req_q.wdata),
        .raddr (req_q.raddr),
        .rdata (store_rdata)
    );

    // x0-style address zero is always usable
    always_comb begin
        if (req_q.raddr == '0) begin
            rd_valid = 1'b1;
        end else if (req_q.raddr == hazard_q) begin
            rd_valid = 1'b0;
        end else if (req_q.raddr == exec_q.addr) begin
            rd_valid = exec_q.en;
        end else if (req_q.raddr == cushion_q.addr) begin
            rd_valid = cushion_q.en;
        end else begin
            rd_valid = 1'b1;
        end
    end

    // youngest in-flight value wins over older ones and over storage
    always_comb begin
        if (req_q.raddr == '0) begin
            rd_data = '0;
        end else if (req_q.raddr == exec_q.addr) begin
            rd_data = exec_q.data;
        end else if (req_q.raddr == cushion_q.addr) begin
            rd_data = cushion_q.data;
        end else if (req_q.wen && req_q.waddr == req_q.raddr) begin
            rd_data = req_q.wdata;
        end else begin
            rd_data = store_rdata;
        end
    end

    always_comb begin
        slot_rsp = '{
            valid: rd_valid,
            hart:  req_q.hart,
            raddr: req_q.raddr,
            rdata: rd_data
        };
    end

endmodule

/* hw/csr_dispatch.sv */
`include "csr_defines.svh"

module csr_dispatch (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  req_strobe,
    input  csr_pkg::csr_req_t     req,
    input  logic                  stall,
    input  logic                  mem_wait,
    input  logic [`CSR_HARTS-1:0] flush,
    output logic [`CSR_HARTS-1:0] sel
);
    import csr_pkg::*;

    logic accept;

    // a request only moves on when the pipe is free and its hart is not flushed
    assign accept = req_strobe && !stall && !mem_wait && !flush[req.hart];

    // one-hot select of the requesting hart's slice
    for (genvar i = 0; i < `CSR_HARTS; i++) begin : g_sel
        assign sel[i] = accept && (req.hart == hart_id_t'(i));
    end

    // a request offered to a free pipe must name an existing slice
    property p_hart_in_range;
        @(posedge CLK) disable iff (rst)
            (req_strobe && !stall && !mem_wait) |->
                (!$isunknown(req.hart) && int'(req.hart) < `CSR_HARTS);
    endproperty

    a_hart_in_range: assert property (p_hart_in_range)
        else $error("offered request names hart %0d", req.hart);

endmodule

/* hw/csr_response_merge.sv */
`include "csr_defines.svh"

module csr_response_merge (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic [`CSR_HARTS-1:0] slot_strobe,
    input  csr_pkg::csr_rsp_t     slot_rsp [`CSR_HARTS],
    output logic                  rsp_strobe,
    output csr_pkg::csr_rsp_t     rsp
);
    import csr_pkg::*;

    csr_rsp_t pick;
    logic     any_strobe;

    // at most one slot is active, so a plain scan is enough
    always_comb begin
        pick = '0;
        for (int i = 0; i < `CSR_HARTS; i++) begin
            if (slot_strobe[i]) begin
                pick = slot_rsp[i];
            end
        end
    end

    assign any_strobe = |slot_strobe;

    always_ff @(posedge CLK) begin
        if (rst) begin
            rsp_strobe <= 1'b0;
        end else begin
            rsp_strobe <= any_strobe;
        end
    end

    always_ff @(posedge CLK) begin
        if (any_strobe) begin
            rsp <= pick;
        end
    end

    // dispatch hands out one request per cycle, slices must not collide
    property p_single_slot;
        @(posedge CLK) disable iff (rst)
            $onehot0(slot_strobe);
    endproperty

    a_single_slot: assert property (p_single_slot)
        else $error("several slots strobe at once: %b", slot_strobe);

endmodule

/* hw/csr_unit_top.sv */
`include "csr_defines.svh"

module csr_unit_top (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  req_strobe,
    input  csr_pkg::csr_req_t     req,
    input  csr_pkg::csr_addr_t    hazard_addr,
    input  csr_pkg::csr_fwd_t     fwd_exec,
    input  csr_pkg::csr_fwd_t     fwd_cushion,
    input  logic                  stall,
    input  logic                  mem_wait,
    input  logic [`CSR_HARTS-1:0] flush,
    output logic                  rsp_strobe,
    output csr_pkg::csr_rsp_t     rsp
);
    import csr_pkg::*;

    logic [`CSR_HARTS-1:0] sel;
    logic [`CSR_HARTS-1:0] slot_strobe;
    csr_rsp_t              slot_rsp [`CSR_HARTS];

    csr_dispatch u_dispatch (
        .CLK        (CLK),
        .rst        (rst),
        .req_strobe (req_strobe),
        .req        (req),
        .stall      (stall),
        .mem_wait   (mem_wait),
        .flush      (flush),
        .sel        (sel)
    );

    // one slice per hart, all see the same request and forwarding buses
    for (genvar i = 0; i < `CSR_HARTS; i++) begin : g_slice
        csr_forward_read u_slice (
            .CLK         (CLK),
            .rst         (rst),
            .flush       (flush[i]),
            .stall       (stall),
            .mem_wait    (mem_wait),
            .sel         (sel[i]),
            .req         (req),
            .hazard_addr (hazard_addr),
            .fwd_exec    (fwd_exec),
            .fwd_cushion (fwd_cushion),
            .slot_strobe (slot_strobe[i]),
            .slot_rsp    (slot_rsp[i])
        );
    end

    csr_response_merge u_merge (
        .CLK         (CLK),
        .rst         (rst),
        .slot_strobe (slot_strobe),
        .slot_rsp    (slot_rsp),
        .rsp_strobe  (rsp_strobe),
        .rsp         (rsp)
    );

endmodule

/* testbench/csr_unit_tb.sv */
`include "csr_defines.svh"

module csr_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import csr_pkg::*;

    localparam int RESET_CYCLES   = 8;
    localparam int RSP_WAIT_MAX   = 16;
    localparam int N_RANDOM       = 60;
    // directed requests plus random ones, each takes four cycles
    localparam int N_REQS         = 90 + N_RANDOM;
    localparam int CONTROL_CYCLES = 40;
    localparam int CYCLE_LIMIT    = RESET_CYCLES + 4 * N_REQS + CONTROL_CYCLES + 100;
    localparam csr_addr_t UNIMPL_ADDR = 12'h7c0;

    logic                  CLK = 1'b0;
    logic                  rst;
    logic                  req_strobe;
    csr_req_t              req;
    csr_addr_t             hazard_addr;
    csr_fwd_t              fwd_exec;
    csr_fwd_t              fwd_cushion;
    logic                  stall;
    logic                  mem_wait;
    logic [`CSR_HARTS-1:0] flush;
    logic                  rsp_strobe;
    csr_rsp_t              rsp;

    // expected contents of the five CSRs of every hart
    csr_data_t model_csr [`CSR_HARTS][5];
    int        seed = 32'h21c1;
    int        cycles = 0;

    csr_unit_top dut0 (
        .CLK         (CLK),
        .rst         (rst),
        .req_strobe  (req_strobe),
        .req         (req),
        .hazard_addr (hazard_addr),
        .fwd_exec    (fwd_exec),
        .fwd_cushion (fwd_cushion),
        .stall       (stall),
        .mem_wait    (mem_wait),
        .flush       (flush),
        .rsp_strobe  (rsp_strobe),
        .rsp         (rsp)
    );

    always #2 CLK = ~CLK;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            report_failure($sformatf("timeout: run went past %0d cycles", CYCLE_LIMIT));
        end
    end

    function automatic int csr_index(csr_addr_t a);
        case (a)
            `CSR_MSTATUS:  return 0;
            `CSR_MTVEC:    return 1;
            `CSR_MSCRATCH: return 2;
            `CSR_MEPC:     return 3;
            `CSR_MCAUSE:   return 4;
            default:       return -1;
        endcase
    endfunction

    // index 5 and above stands for an unimplemented CSR
    function automatic csr_addr_t csr_at(int k);
        case (k)
            0:       return `CSR_MSTATUS;
            1:       return `CSR_MTVEC;
            2:       return `CSR_MSCRATCH;
            3:       return `CSR_MEPC;
            4:       return `CSR_MCAUSE;
            default: return UNIMPL_ADDR;
        endcase
    endfunction

    function automatic csr_req_t make_req(int h, csr_addr_t ra, logic w, csr_addr_t wa,
                                          csr_data_t wd);
        csr_req_t r;
        r.hart  = hart_id_t'(h);
        r.raddr = ra;
        r.wen   = w;
        r.waddr = wa;
        r.wdata = wd;
        return r;
    endfunction

    function automatic csr_fwd_t fwd_src(logic en, csr_addr_t a, csr_data_t d);
        csr_fwd_t f;
        f.en   = en;
        f.addr = a;
        f.data = d;
        return f;
    endfunction

    function automatic logic [`CSR_HARTS-1:0] hart_mask(int h);
        logic [`CSR_HARTS-1:0] m;
        m    = '0;
        m[h] = 1'b1;
        return m;
    endfunction

    function automatic csr_data_t model_read(csr_req_t r);
        int idx;
        idx = csr_index(r.raddr);
        if (idx < 0) begin
            return '0;
        end
        return model_csr[r.hart][idx];
    endfunction

    // read priority: zero address, then in-flight values, own write, storage
    function automatic csr_rsp_t expect_rsp(csr_req_t r, csr_addr_t hz, csr_fwd_t fe,
                                            csr_fwd_t fc);
        csr_rsp_t e;
        e.hart  = r.hart;
        e.raddr = r.raddr;
        e.valid = 1'b1;
        if (r.raddr == 12'h000) begin
            e.rdata = '0;
            return e;
        end
        if (r.raddr == fe.addr) begin
            e.rdata = fe.data;
            e.valid = fe.en;
        end else if (r.raddr == fc.addr) begin
            e.rdata = fc.data;
            e.valid = fc.en;
        end else if (r.wen && r.waddr == r.raddr) begin
            e.rdata = r.wdata;
        end else begin
            e.rdata = model_read(r);
        end
        // unresolved hazard only blocks use, data still follows the other rules
        if (r.raddr == hz) begin
            e.valid = 1'b0;
        end
        return e;
    endfunction

    task automatic model_commit(input csr_req_t r);
        int idx;
        idx = csr_index(r.waddr);
        if (r.wen && idx >= 0) begin
            model_csr[r.hart][idx] = r.wdata;
        end
    endtask

    task automatic check_rsp(input csr_rsp_t got, input csr_rsp_t exp);
        if (got.valid !== exp.valid) begin
            report_failure($sformatf("MISMATCH rsp.valid got %h expected %h",
                                     got.valid, exp.valid));
        end
        if (got.hart !== exp.hart) begin
            report_failure($sformatf("MISMATCH rsp.hart got %h expected %h",
                                     got.hart, exp.hart));
        end
        if (got.raddr !== exp.raddr) begin
            report_failure($sformatf("MISMATCH rsp.raddr got %h expected %h",
                                     got.raddr, exp.raddr));
        end
        if (got.rdata !== exp.rdata) begin
            report_failure($sformatf("MISMATCH rsp.rdata got %h expected %h (raddr %h)",
                                     got.rdata, exp.rdata, exp.raddr));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("MISMATCH response latency got %h expected %h", got, exp));
        end
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge CLK);
            if (rsp_strobe !== 1'b0) begin
                report_failure($sformatf("MISMATCH rsp_strobe got %h expected %h",
                                         rsp_strobe, 1'b0));
            end
        end
    endtask

    // counts rising edges from the call until rsp_strobe is seen
    task automatic wait_rsp(output int edges);
        edges = 0;
        @(negedge CLK);
        while (rsp_strobe !== 1'b1) begin
            if (edges >= RSP_WAIT_MAX) begin
                report_failure($sformatf("no response within %0d cycles", RSP_WAIT_MAX));
            end
            @(negedge CLK);
            edges++;
        end
    endtask

    task automatic issue(input csr_req_t r, input csr_addr_t hz, input csr_fwd_t fe,
                         input csr_fwd_t fc);
        @(posedge CLK);
        req_strobe  <= 1'b1;
        req         <= r;
        hazard_addr <= hz;
        fwd_exec    <= fe;
        fwd_cushion <= fc;
        @(posedge CLK);
        req_strobe  <= 1'b0;
        req         <= '0;
        hazard_addr <= '0;
        fwd_exec    <= '0;
        fwd_cushion <= '0;
    endtask

    task automatic run_req(input csr_req_t r, input csr_addr_t hz, input csr_fwd_t fe,
                           input csr_fwd_t fc);
        csr_rsp_t exp;
        int       edges;
        exp = expect_rsp(r, hz, fe, fc);
        issue(r, hz, fe, fc);
        wait_rsp(edges);
        // issue already passed the capture edge
        check_latency(edges + 1, 2);
        check_rsp(rsp, exp);
        model_commit(r);
        check_quiet(1);
    endtask

    task automatic test_reset_values();
        check_quiet(10);
        for (int h = 0; h < `CSR_HARTS; h++) begin
            for (int k = 0; k < 5; k++) begin
                run_req(make_req(h, csr_at(k), 1'b0, '0, '0), '0, '0, '0);
            end
        end
    endtask

    task automatic test_write_read();
        csr_data_t data;
        for (int h = 0; h < `CSR_HARTS; h++) begin
            for (int k = 0; k < 5; k++) begin
                data = {8'(h + 1), 8'(k), 16'hc5a0};
                run_req(make_req(h, csr_at(k), 1'b1, csr_at(k), data), '0, '0, '0);
            end
            // the next hart must not see these writes
            run_req(make_req((h + 1) % `CSR_HARTS, `CSR_MSTATUS, 1'b0, '0, '0), '0, '0, '0);
        end
        run_req(make_req(2, UNIMPL_ADDR, 1'b1, UNIMPL_ADDR, 32'hdead_beef), '0, '0, '0);
        run_req(make_req(2, UNIMPL_ADDR, 1'b0, '0, '0), '0, '0, '0);
        for (int h = 0; h < `CSR_HARTS; h++) begin
            for (int k = 0; k < 5; k++) begin
                run_req(make_req(h, csr_at(k), 1'b0, '0, '0), '0, '0, '0);
            end
        end
    endtask

    task automatic test_forwarding();
        run_req(make_req(1, `CSR_MSCRATCH, 1'b0, '0, '0), '0,
                fwd_src(1'b1, `CSR_MSCRATCH, 32'h1234_5678), '0);
        run_req(make_req(1, `CSR_MSCRATCH, 1'b0, '0, '0), '0,
                fwd_src(1'b0, `CSR_MSCRATCH, 32'h0bad_f00d), '0);
        run_req(make_req(1, `CSR_MEPC, 1'b0, '0, '0), '0,
                fwd_src(1'b1, `CSR_MEPC, 32'haaaa_0001), fwd_src(1'b1, `CSR_MEPC, 32'h5555_0002));
        run_req(make_req(1, `CSR_MTVEC, 1'b0, '0, '0), '0,
                fwd_src(1'b1, `CSR_MEPC, 32'haaaa_0003), fwd_src(1'b1, `CSR_MTVEC, 32'h5555_0004));
    endtask

    task automatic test_special_addr();
        run_req(make_req(2, `CSR_MCAUSE, 1'b0, '0, '0), `CSR_MCAUSE, '0, '0);
        run_req(make_req(2, `CSR_MTVEC, 1'b0, '0, '0), `CSR_MTVEC,
                fwd_src(1'b1, `CSR_MTVEC, 32'h7777_8888), '0);
        // address zero wins over hazard, forwarding and its own write
        run_req(make_req(2, 12'h000, 1'b1, 12'h000, 32'h1111_2222), 12'h000,
                fwd_src(1'b1, 12'h000, 32'h3333_4444), fwd_src(1'b1, 12'h000, 32'h5555_6666));
    endtask

    task automatic test_control();
        csr_req_t r;
        csr_rsp_t exp;
        int       edges;
        r   = make_req(2, `CSR_MEPC, 1'b1, `CSR_MEPC, 32'h0ee0_1234);
        exp = expect_rsp(r, '0, '0, '0);
        @(posedge CLK);
        req_strobe <= 1'b1;
        req        <= r;
        @(posedge CLK);
        req_strobe <= 1'b0;
        req        <= '0;
        mem_wait   <= 1'b1;
        check_quiet(3);
        @(posedge CLK);
        mem_wait <= 1'b0;
        wait_rsp(edges);
        // answer registers on the first edge that samples mem_wait low
        check_latency(edges, 1);
        check_rsp(rsp, exp);
        model_commit(r);
        check_quiet(3);
        run_req(make_req(2, `CSR_MEPC, 1'b0, '0, '0), '0, '0, '0);

        // flushed in its own cycle, never accepted
        @(posedge CLK);
        req_strobe <= 1'b1;
        req        <= make_req(3, `CSR_MSCRATCH, 1'b1, `CSR_MSCRATCH, 32'hf1f1_0003);
        flush      <= hart_mask(3);
        @(posedge CLK);
        req_strobe <= 1'b0;
        req        <= '0;
        flush      <= '0;
        check_quiet(4);

        // captured, held by mem_wait, then flushed
        @(posedge CLK);
        req_strobe <= 1'b1;
        req        <= make_req(0, `CSR_MSCRATCH, 1'b1, `CSR_MSCRATCH, 32'hf1f1_0000);
        @(posedge CLK);
        req_strobe <= 1'b0;
        req        <= '0;
        mem_wait   <= 1'b1;
        flush      <= hart_mask(0);
        @(posedge CLK);
        mem_wait <= 1'b0;
        flush    <= '0;
        check_quiet(4);

        @(posedge CLK);
        req_strobe <= 1'b1;
        req        <= make_req(1, `CSR_MCAUSE, 1'b1, `CSR_MCAUSE, 32'h5a5a_0001);
        stall      <= 1'b1;
        @(posedge CLK);
        req_strobe <= 1'b0;
        req        <= '0;
        stall      <= 1'b0;
        check_quiet(4);

        // dropped writes left storage alone
        run_req(make_req(3, `CSR_MSCRATCH, 1'b0, '0, '0), '0, '0, '0);
        run_req(make_req(0, `CSR_MSCRATCH, 1'b0, '0, '0), '0, '0, '0);
        run_req(make_req(1, `CSR_MCAUSE, 1'b0, '0, '0), '0, '0, '0);
    endtask

    task automatic test_random();
        int unsigned u;
        int          h;
        csr_addr_t   ra;
        logic        w;
        csr_addr_t   wa;
        csr_data_t   wd;
        for (int n = 0; n < N_RANDOM; n++) begin
            u  = $random(seed);
            h  = int'(u % `CSR_HARTS);
            u  = $random(seed);
            ra = csr_at(int'(u % 6));
            u  = $random(seed);
            w  = u[0];
            wa = csr_at(int'((u >> 1) % 6));
            wd = $random(seed);
            run_req(make_req(h, ra, w, wa, wd), '0, '0, '0);
        end
    endtask

    initial begin
        rst         <= 1'b1;
        req_strobe  <= 1'b0;
        req         <= '0;
        hazard_addr <= '0;
        fwd_exec    <= '0;
        fwd_cushion <= '0;
        stall       <= 1'b0;
        mem_wait    <= 1'b0;
        flush       <= '0;
        for (int h = 0; h < `CSR_HARTS; h++) begin
            for (int k = 0; k < 5; k++) begin
                model_csr[h][k] = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        rst <= 1'b0;

        test_reset_values();
        test_write_read();
        test_forwarding();
        test_special_addr();
        test_control();
        test_random();

        $display("Everything OK");
        $finish;
    end

endmodule

/* files.f */
+incdir+common
common/csr_pkg.sv
csr/csr_storage.sv
csr/csr_forward_read.sv
hw/csr_dispatch.sv
hw/csr_response_merge.sv
hw/csr_unit_top.sv
testbench/csr_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the CSR read stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
    -f files.f \
    --top-module csr_unit_tb \
    --Mdir obj_dir \
    -o csr_unit_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/csr_unit_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$SIM_LOG"; then
    exit 0
fi
exit 1
